// ==== filelist.f ====
source/ocd_pkg.sv
source/ocd_prbs_ref.sv
source/ocd_data_cmp.sv
source/ocd_result_tracker.sv
source/ocd_calib_top.sv
testbench/tb_clock.sv
testbench/ocd_calib_checker.sv
testbench/tb_ocd_calib.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_ocd_calib -o sim_ocd &&
./obj_dir/sim_ocd | tee /dev/stderr | grep -q "Everything OK" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== source/ocd_calib_top.sv ====
`timescale 1ns/1ps

module ocd_calib_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [ocd_pkg::ROW_W-1:0]      rddata,
  input  logic                           rddata_en,
  input  logic                           complex_mode,
  input  logic [ocd_pkg::LANE_SEL_W-1:0] lane_sel,
  input  logic                           ignore_first,
  input  logic                           ignore_last,
  input  logic                           prbs_restart,
  input  logic                           clear_results,
  output logic [1:0]                     match,
  output logic                           match_valid,
  output logic [ocd_pkg::CNT_W-1:0]      read_count,
  output logic [1:0]                     all_pass
);

  import ocd_pkg::*;

  logic [ROW_W-1:0] exp_row;             // One cycle behind its read

  ocd_prbs_ref i_ocd_prbs_ref (
    .clk          (clk),
    .rst          (rst),
    .rddata_en    (rddata_en),
    .prbs_restart (prbs_restart),
    .exp_row      (exp_row)
  );

  ocd_data_cmp i_ocd_data_cmp (
    .clk          (clk),
    .rst          (rst),
    .rddata       (rddata),
    .rddata_en    (rddata_en),
    .exp_row      (exp_row),
    .complex_mode (complex_mode),
    .lane_sel     (lane_sel),
    .ignore_first (ignore_first),
    .ignore_last  (ignore_last),
    .match        (match),
    .match_valid  (match_valid)
  );

  ocd_result_tracker i_ocd_result_tracker (
    .clk           (clk),
    .rst           (rst),
    .match         (match),
    .match_valid   (match_valid),
    .clear_results (clear_results),
    .read_count    (read_count),
    .all_pass      (all_pass)
  );

endmodule

// ==== source/ocd_data_cmp.sv ====
`timescale 1ns/1ps

module ocd_data_cmp (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [ocd_pkg::ROW_W-1:0]      rddata,
  input  logic                           rddata_en,
  input  logic [ocd_pkg::ROW_W-1:0]      exp_row,
  input  logic                           complex_mode,
  input  logic [ocd_pkg::LANE_SEL_W-1:0] lane_sel,
  input  logic                           ignore_first,
  input  logic                           ignore_last,
  output logic [1:0]                     match,
  output logic                           match_valid
);

  import ocd_pkg::*;

  logic [BYTES_W-1:0] data_bytes_ns;
  logic [BYTES_W-1:0] exp_bytes_ns;
  logic [BYTES_W-1:0] data_bytes_r1;
  logic [BYTES_W-1:0] data_bytes_r2;
  logic [BYTES_W-1:0] exp_bytes_r;
  logic [BYTES_W-1:0] data_bytes;
  logic               en_r1;
  logic               en_r2;
  logic               ignore_first_r;
  logic               ignore_last_r;
  logic [7:0]         last_byte_r;
  logic [BEATS-1:0]   comp0;
  logic [BEATS-1:0]   comp180;
  logic [BEATS-1:0]   prbs0;
  logic [BEATS-1:0]   prbs180;

  // ==========================================================================
  // Lane extraction and alignment
  // ==========================================================================

  always_comb begin
    for (int b = 0; b < BEATS; b++) begin
      data_bytes_ns[b*8 +: 8] = rddata[b*DQ_WIDTH + lane_sel*8 +: 8];
      exp_bytes_ns[b*8 +: 8]  = exp_row[b*DQ_WIDTH + lane_sel*8 +: 8];
    end
  end

  always_ff @(posedge clk) begin
    data_bytes_r1  <= data_bytes_ns;     // Simple mode compares here
    data_bytes_r2  <= data_bytes_r1;     // Lines up with exp_bytes_r
    exp_bytes_r    <= exp_bytes_ns;      // exp_row already lags by one
    ignore_first_r <= ignore_first;
    ignore_last_r  <= ignore_last;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      en_r1 <= 1'b0;
      en_r2 <= 1'b0;
    end else begin
      en_r1 <= rddata_en;
      en_r2 <= en_r1;
    end
  end

  assign data_bytes  = complex_mode ? data_bytes_r2 : data_bytes_r1;
  assign match_valid = complex_mode ? en_r2 : en_r1;

  // Final beat of each compared read feeds beat 0 of the next shifted check
  always_ff @(posedge clk) begin
    if (rst) begin
      last_byte_r <= 8'h00;
    end else if (match_valid) begin
      last_byte_r <= data_bytes[BYTES_W-1 -: 8];
    end
  end

  // ==========================================================================
  // Pattern comparisons
  // ==========================================================================

  always_comb begin
    for (int b = 0; b < BEATS; b++) begin
      comp0[b]   = data_bytes[b*8 +: 8] == ((b % 2 == 1) ? 8'hFF : 8'h00);
      comp180[b] = data_bytes[b*8 +: 8] == ((b % 2 == 1) ? 8'h00 : 8'hFF);
      prbs0[b]   = data_bytes[b*8 +: 8] == exp_bytes_r[b*8 +: 8];
    end

    // Shifted by one beat
    prbs180[0] = last_byte_r == exp_bytes_r[7:0];
    for (int b = 1; b < BEATS; b++) begin
      prbs180[b] = data_bytes[(b-1)*8 +: 8] == exp_bytes_r[b*8 +: 8];
    end

    // Edge beats can be unreliable while the delay sweeps
    if (ignore_last_r) begin
      prbs0[BEATS-1]   = 1'b1;
      prbs0[BEATS-2]   = 1'b1;
      prbs180[BEATS-1] = 1'b1;
    end
    if (ignore_first_r) begin
      prbs180[0] = 1'b1;
    end
  end

  always_comb begin
    match = 2'b00;
    if (complex_mode) begin
      match[PH_0]   = &prbs0;
      match[PH_180] = &prbs180;
    end else begin
      match[PH_0]   = &comp0;
      match[PH_180] = &comp180;
    end
  end

endmodule

// ==== source/ocd_pkg.sv ====
package ocd_pkg;

  // ==========================================================================
  // Read row geometry
  // ==========================================================================

  localparam int NCK_PER_CLK = 4;                 // Memory clocks per fabric clock
  localparam int BEATS       = 2 * NCK_PER_CLK;   // DDR, two beats per clock
  localparam int LANES       = 8;
  localparam int DQ_WIDTH    = LANES * 8;
  localparam int LANE_SEL_W  = $clog2(LANES);
  localparam int ROW_W       = BEATS * DQ_WIDTH;  // One full read row
  localparam int BYTES_W     = BEATS * 8;         // Selected lane, all beats

  // ==========================================================================
  // PRBS reference
  // ==========================================================================

  // Galois mask for x^8+x^6+x^5+x^4+1, right-shifting form
  localparam logic [7:0] PRBS_TAPS = 8'hB8;
  localparam logic [7:0] PRBS_SEED = 8'h5A;       // Must be nonzero

  // ==========================================================================
  // Results
  // ==========================================================================

  localparam int CNT_W = 16;

  // Bit positions inside the 2-bit match value
  localparam int PH_0   = 0;
  localparam int PH_180 = 1;

endpackage

// ==== source/ocd_prbs_ref.sv ====
`timescale 1ns/1ps

module ocd_prbs_ref (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      rddata_en,
  input  logic                      prbs_restart,
  output logic [ocd_pkg::ROW_W-1:0] exp_row
);

  import ocd_pkg::*;

  // One Galois step, LSB shifts out and folds back through the taps
  function automatic logic [7:0] prbs_step(input logic [7:0] state);
    logic [7:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ PRBS_TAPS;
    end
    return next;
  endfunction

  logic [7:0]              lfsr;
  logic [7:0]              start_state;
  logic [BEATS:0][7:0]     steps;        // State seen by each beat, plus the carry-out
  logic [ROW_W-1:0]        row_ns;

  // A restart in the same cycle as a read makes that read start from the seed
  assign start_state = prbs_restart ? PRBS_SEED : lfsr;

  always_comb begin
    steps[0] = start_state;
    for (int b = 0; b < BEATS; b++) begin
      steps[b+1] = prbs_step(steps[b]);
    end
  end

  // Every lane of a beat carries the same byte, so any lane_sel finds it
  always_comb begin
    for (int b = 0; b < BEATS; b++) begin
      row_ns[b*DQ_WIDTH +: DQ_WIDTH] = {LANES{steps[b]}};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= PRBS_SEED;
    end else if (rddata_en) begin
      lfsr <= steps[BEATS];              // Eight steps per row
    end else if (prbs_restart) begin
      lfsr <= PRBS_SEED;
    end
  end

  always_ff @(posedge clk) begin
    if (rddata_en) begin
      exp_row <= row_ns;                 // Holds until the next read
    end
  end

endmodule

// ==== source/ocd_result_tracker.sv ====
`timescale 1ns/1ps

module ocd_result_tracker (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [1:0]                match,
  input  logic                      match_valid,
  input  logic                      clear_results,
  output logic [ocd_pkg::CNT_W-1:0] read_count,
  output logic [1:0]                all_pass
);

  import ocd_pkg::*;

  logic count_full;

  assign count_full = &read_count;       // Saturate instead of wrapping

  always_ff @(posedge clk) begin
    if (rst || clear_results) begin
      read_count <= '0;
    end else if (match_valid && !count_full) begin
      read_count <= read_count + 1'b1;
    end
  end

  // ==========================================================================
  // Sticky pass flags, one per phase
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (rst || clear_results) begin
      all_pass <= 2'b11;
    end else if (match_valid) begin
      all_pass[PH_0]   <= all_pass[PH_0] & match[PH_0];
      all_pass[PH_180] <= all_pass[PH_180] & match[PH_180];
    end
  end

endmodule

// ==== testbench/ocd_calib_checker.sv ====
`timescale 1ns/1ps

module ocd_calib_checker (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [ocd_pkg::ROW_W-1:0]      rddata,
  input  logic                           rddata_en,
  input  logic                           complex_mode,
  input  logic [ocd_pkg::LANE_SEL_W-1:0] lane_sel,
  input  logic                           ignore_first,
  input  logic                           ignore_last,
  input  logic                           prbs_restart,
  input  logic                           clear_results,
  input  logic [127:0]                   test_name,
  input  logic [1:0]                     match,
  input  logic                           match_valid,
  input  logic [ocd_pkg::CNT_W-1:0]      read_count,
  input  logic [1:0]                     all_pass,
  output int                             errors
);

  import ocd_pkg::*;

  logic [7:0]       model_lfsr;
  logic [7:0]       carried;
  logic             s1_v, s1_c, s2_v, s2_c;
  logic [1:0]       s1_m, s2_m;
  logic [127:0]     s1_name, s2_name;
  logic [CNT_W-1:0] exp_count;
  logic [1:0]       exp_pass;

  // x^8+x^6+x^5+x^4+1 in right-shifting Galois form
  function automatic logic [7:0] advance_lfsr(input logic [7:0] s);
    logic [7:0] r;
    r = {1'b0, s[7:1]};
    if (s[0]) r = r ^ 8'hB8;
    return r;
  endfunction

  // Expected verdict for the read strobed this cycle
  task automatic predict_read(output logic [1:0] m);
    logic [7:0] d [BEATS];
    logic [7:0] e [BEATS];
    logic [7:0] s;
    logic       p0, p180;
    s = prbs_restart ? PRBS_SEED : model_lfsr;
    for (int b = 0; b < BEATS; b++) begin
      d[b] = rddata[b*DQ_WIDTH + int'(lane_sel)*8 +: 8];
      e[b] = s;
      s = advance_lfsr(s);
    end
    model_lfsr = s;
    p0 = 1'b1;
    p180 = 1'b1;
    for (int b = 0; b < BEATS; b++) begin
      if (!complex_mode) begin
        if (d[b] != ((b % 2) ? 8'hFF : 8'h00)) p0 = 1'b0;
        if (d[b] != ((b % 2) ? 8'h00 : 8'hFF)) p180 = 1'b0;
      end else begin
        if (d[b] != e[b] && !(ignore_last && b >= 6)) p0 = 1'b0;
        if (b == 0) begin
          if (carried != e[0] && !ignore_first) p180 = 1'b0;
        end else if (d[b-1] != e[b] && !(ignore_last && b == 7)) begin
          p180 = 1'b0;
        end
      end
    end
    carried = d[BEATS-1];
    m = {p180, p0};
  endtask

  always @(posedge clk) begin
    logic         due_v;
    logic [1:0]   due_m;
    logic [127:0] due_name;
    if (rst) begin
      model_lfsr = PRBS_SEED;
      carried    = 8'h00;
      s1_v       = 1'b0;
      s2_v       = 1'b0;
      exp_count  = '0;
      exp_pass   = 2'b11;
    end else begin
      due_v    = (s1_v && !s1_c) || (s2_v && s2_c);
      due_m    = (s1_v && !s1_c) ? s1_m : s2_m;
      due_name = (s1_v && !s1_c) ? s1_name : s2_name;
      if (match_valid !== due_v) begin
        $display("Mismatch %0s: match_valid expected %b actual %b", test_name, due_v,
                 match_valid);
        errors++;
      end
      if (due_v && match !== due_m) begin
        $display("Mismatch %0s: match expected %b actual %b", due_name, due_m, match);
        errors++;
      end
      if (read_count !== exp_count) begin
        $display("Mismatch %0s: read_count expected %0d actual %0d", test_name, exp_count,
                 read_count);
        errors++;
      end
      if (all_pass !== exp_pass) begin
        $display("Mismatch %0s: all_pass expected %b actual %b", test_name, exp_pass,
                 all_pass);
        errors++;
      end
      // Tracker model
      if (clear_results) begin
        exp_count = '0;
        exp_pass  = 2'b11;
      end else if (due_v) begin
        exp_count = exp_count + 1'b1;
        exp_pass  = exp_pass & due_m;
      end
      // Reads in flight
      s2_v    = s1_v;
      s2_c    = s1_c;
      s2_m    = s1_m;
      s2_name = s1_name;
      s1_v    = rddata_en;
      s1_c    = complex_mode;
      s1_name = test_name;
      if (rddata_en) predict_read(s1_m);
      else if (prbs_restart) model_lfsr = PRBS_SEED;
    end
  end

  initial errors = 0;

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;               // 10 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// ==== testbench/tb_ocd_calib.sv ====
`timescale 1ns/1ps

module tb_ocd_calib;

  import ocd_pkg::*;

  localparam int NUM_ROWS    = 18;
  localparam int CYC_PER_ROW = 10;
  localparam int CYC_LIMIT   = NUM_ROWS * CYC_PER_ROW + 60;

  localparam logic [1:0] TOGGLE = 2'd0, INVERSE = 2'd1, PRBS = 2'd2, PRBS_SHIFT = 2'd3;

  // When the seed reload happens relative to the read
  localparam logic [1:0] RESTART_NONE  = 2'd0;
  localparam logic [1:0] RESTART_SAME  = 2'd1;
  localparam logic [1:0] RESTART_AHEAD = 2'd2;

  typedef struct packed {
    logic [127:0] name;
    logic         cplx;
    logic [2:0]   lane;
    logic         igf;
    logic         igl;
    logic [1:0]   kind;
    logic [3:0]   bad;                   // 4'hF means no corruption
    logic         bad_other;
    logic         b2b;
    logic [1:0]   restart;
    logic         clear;
  } row_t;

  logic                  clk, rst;
  logic [ROW_W-1:0]      rddata;
  logic                  rddata_en, complex_mode, ignore_first, ignore_last;
  logic                  prbs_restart, clear_results;
  logic [LANE_SEL_W-1:0] lane_sel;
  logic [1:0]            match, all_pass;
  logic                  match_valid;
  logic [CNT_W-1:0]      read_count;
  logic [127:0]          test_name;
  int                    errors, tb_errors, issued, done_cnt, cycles;
  logic [31:0]           rnd;
  logic [7:0]            gen_lfsr;
  row_t                  rows [NUM_ROWS];

  tb_clock i_tb_clock (.clk(clk), .rst(rst));

  ocd_calib_top i_ocd_calib_top (
    .clk(clk), .rst(rst), .rddata(rddata), .rddata_en(rddata_en),
    .complex_mode(complex_mode), .lane_sel(lane_sel), .ignore_first(ignore_first),
    .ignore_last(ignore_last), .prbs_restart(prbs_restart), .clear_results(clear_results),
    .match(match), .match_valid(match_valid), .read_count(read_count), .all_pass(all_pass)
  );

  ocd_calib_checker i_checker (
    .clk(clk), .rst(rst), .rddata(rddata), .rddata_en(rddata_en),
    .complex_mode(complex_mode), .lane_sel(lane_sel), .ignore_first(ignore_first),
    .ignore_last(ignore_last), .prbs_restart(prbs_restart), .clear_results(clear_results),
    .test_name(test_name), .match(match), .match_valid(match_valid),
    .read_count(read_count), .all_pass(all_pass), .errors(errors)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return s[0] ? ({1'b0, s[7:1]} ^ 8'hB8) : {1'b0, s[7:1]};
  endfunction

  // Random filler everywhere, then the pattern on the selected lane
  task automatic build_row(input row_t r, output logic [ROW_W-1:0] data);
    logic [7:0] e [BEATS+1];
    logic [7:0] v;
    int         other;
    if (r.restart != RESTART_NONE) gen_lfsr = PRBS_SEED;
    e[0] = gen_lfsr;
    for (int b = 0; b < BEATS; b++) e[b+1] = lfsr_step(e[b]);
    gen_lfsr = e[BEATS];
    for (int w = 0; w < ROW_W / 32; w++) begin
      rnd = xorshift32(rnd);
      data[w*32 +: 32] = rnd;
    end
    for (int b = 0; b < BEATS; b++) begin
      case (r.kind)
        TOGGLE:  v = (b % 2) ? 8'hFF : 8'h00;
        INVERSE: v = (b % 2) ? 8'h00 : 8'hFF;
        PRBS:    v = e[b];
        default: v = e[b+1];              // One beat early
      endcase
      if (r.bad == 4'(b)) v = v ^ 8'h01;
      data[b*DQ_WIDTH + int'(r.lane)*8 +: 8] = v;
    end
    if (r.bad_other) begin
      other = (int'(r.lane) + 1) % LANES;
      data[3*DQ_WIDTH + other*8 +: 8] = ~data[3*DQ_WIDTH + other*8 +: 8];
    end
  endtask

  // ==========================================================================
  // Stimulus table
  // ==========================================================================

  initial begin
    //        name               cplx lane igf igl kind      bad  oth b2b restart       clr
    rows[0]  = '{"toggle_l0",      0, 0, 0, 0, TOGGLE,     4'hF, 0, 0, RESTART_NONE,  0};
    rows[1]  = '{"inv_toggle_l5",  0, 5, 0, 0, INVERSE,    4'hF, 0, 0, RESTART_NONE,  0};
    rows[2]  = '{"toggle_bad_b3",  0, 2, 0, 0, TOGGLE,     4'h3, 0, 0, RESTART_NONE,  0};
    rows[3]  = '{"toggle_other",   0, 4, 0, 0, TOGGLE,     4'hF, 1, 0, RESTART_NONE,  0};
    rows[4]  = '{"clear_toggle",   0, 1, 0, 0, TOGGLE,     4'hF, 0, 0, RESTART_NONE,  1};
    rows[5]  = '{"b2b_toggle",     0, 3, 0, 0, TOGGLE,     4'hF, 0, 1, RESTART_NONE,  0};
    rows[6]  = '{"b2b_inverse",    0, 3, 0, 0, INVERSE,    4'hF, 0, 0, RESTART_NONE,  0};
    rows[7]  = '{"prbs_from_reset",1, 0, 0, 0, PRBS,       4'hF, 0, 0, RESTART_NONE,  1};
    rows[8]  = '{"prbs_l6",        1, 6, 0, 0, PRBS,       4'hF, 0, 0, RESTART_NONE,  0};
    rows[9]  = '{"shift_ign_first",1, 2, 1, 0, PRBS_SHIFT, 4'hF, 0, 0, RESTART_NONE,  0};
    rows[10] = '{"shift_carried",  1, 2, 0, 0, PRBS_SHIFT, 4'hF, 0, 0, RESTART_NONE,  0};
    rows[11] = '{"b2b_shift_a",    1, 7, 0, 0, PRBS_SHIFT, 4'hF, 0, 1, RESTART_NONE,  0};
    rows[12] = '{"b2b_shift_b",    1, 7, 0, 0, PRBS_SHIFT, 4'hF, 0, 0, RESTART_NONE,  0};
    rows[13] = '{"shift_ign_b6",   1, 3, 0, 1, PRBS_SHIFT, 4'h6, 0, 0, RESTART_NONE,  0};
    rows[14] = '{"prbs_ign_b6",    1, 1, 0, 1, PRBS,       4'h6, 0, 0, RESTART_NONE,  1};
    rows[15] = '{"restart_ign_b7", 1, 1, 0, 1, PRBS,       4'h7, 0, 0, RESTART_AHEAD, 0};
    rows[16] = '{"prbs_bad_b2",    1, 4, 0, 0, PRBS,       4'h2, 0, 0, RESTART_NONE,  0};
    rows[17] = '{"restart_again",  1, 5, 0, 0, PRBS,       4'hF, 0, 0, RESTART_SAME,  0};
  end

  always @(posedge clk) begin
    if (match_valid) done_cnt++;
    cycles++;
    if (cycles >= CYC_LIMIT) begin
      $display("Run stopped after %0d cycles, the DUT stopped answering reads", CYC_LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    logic [ROW_W-1:0] data;
    int               wait_cyc;
    rddata        = '0;
    rddata_en     = 1'b0;
    complex_mode  = 1'b0;
    lane_sel      = '0;
    ignore_first  = 1'b0;
    ignore_last   = 1'b0;
    prbs_restart  = 1'b0;
    clear_results = 1'b0;
    test_name     = "reset";
    tb_errors     = 0;
    issued        = 0;
    done_cnt      = 0;
    cycles        = 0;
    rnd           = 32'hb889_9dd5;
    gen_lfsr      = PRBS_SEED;
    @(negedge rst);
    @(negedge clk);
    for (int i = 0; i < NUM_ROWS; i++) begin
      test_name = rows[i].name;
      if (rows[i].clear || rows[i].restart == RESTART_AHEAD) begin
        clear_results = rows[i].clear;
        prbs_restart  = (rows[i].restart == RESTART_AHEAD);
        @(negedge clk);
        clear_results = 1'b0;
        prbs_restart  = 1'b0;
      end
      complex_mode = rows[i].cplx;
      lane_sel     = rows[i].lane;
      ignore_first = rows[i].igf;
      ignore_last  = rows[i].igl;
      build_row(rows[i], data);
      rddata       = data;
      rddata_en    = 1'b1;
      prbs_restart = (rows[i].restart == RESTART_SAME);
      issued++;
      @(negedge clk);
      rddata_en    = 1'b0;
      prbs_restart = 1'b0;
      if (!rows[i].b2b) begin
        wait_cyc = 0;
        while (done_cnt < issued && wait_cyc < 6) begin
          @(negedge clk);
          wait_cyc++;
        end
        if (done_cnt < issued) begin
          $display("No match_valid came back for test %0s", test_name);
          tb_errors++;
        end
        @(negedge clk);
      end
    end
    repeat (3) @(negedge clk);
    $display("Errors: %0d from checks, %0d from handshake", errors, tb_errors);
    if (errors + tb_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
